// ==== Makefile ====
TOP = tb_spidergon_node

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f spidergon_node.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only -Wall --timing --assert -f spidergon_node.f --top-module $(TOP)
	verilator --lint-only -Wall spidergon_pkg.sv rr_arbiter.sv vc_fifo.sv input_port.sv \
		output_link.sv spidergon_node.sv --top-module spidergon_node

clean:
	rm -rf obj_dir

// ==== input_port.sv ====
// input link of a node, channel reservation, route latch and two channel fifos
`timescale 1ns/100ps

module input_port import spidergon_pkg::*;
#(
	parameter logic [node_w-1:0] node_id = '0 // ring position of this node
)
(
	input  logic                    clk,
	input  logic                    reset,
	input  flit_link_t              link_in,
	input  logic [num_vcs-1:0]      dequeue, // from the output that won each channel
	output vc_status_t              status, // back to the upstream node
	output vc_head_t [num_vcs-1:0]  heads
);

// idle channels may take a new head, busy ones belong to a packet
typedef enum logic {
	vc_idle,
	vc_busy
} vc_state_e;

logic [num_vcs-1:0] ready;
logic [num_vcs-1:0] fifo_full;
logic [num_vcs-1:0] fifo_empty;
logic [num_vcs-1:0] enq;
logic [num_vcs-1:0] alloc_req;
logic [num_vcs-1:0] alloc_grant;
logic new_packet; // head or header on the link this cycle
logic follow; // body or tail on the link this cycle

assign new_packet = link_in.valid && is_head_like(link_in.flit.kind);
assign follow = link_in.valid && !is_head_like(link_in.flit.kind);

// arbitrate only while a head is there so the pointer moves on real grants
assign alloc_req = new_packet ? ready : '0;

rr_arbiter #(.n(num_vcs)) u_alloc
(
	.clk(clk),
	.reset(reset),
	.req(alloc_req),
	.grant(alloc_grant)
);

genvar v;
generate
	for (v = 0; v < num_vcs; v++)
	begin : g_vc
		vc_state_e state;
		logic [vc_w-1:0] up_tag; // upstream channel holding this packet
		link_dir_e route; // direction latched from the head
		flit_t wr_flit;
		flit_t front;
		logic tag_hit;

		assign ready[v] = (state == vc_idle) && !fifo_full[v];
		assign tag_hit = (state == vc_busy) && (up_tag == link_in.flit.vc);

		// heads go where the arbiter says, followers chase their tag
		assign enq[v] = new_packet ? alloc_grant[v] : (follow && tag_hit && !fifo_full[v]);

		// retag with the local channel so downstream can match followers
		assign wr_flit = '{kind: link_in.flit.kind, vc: vc_w'(v), data: link_in.flit.data};

		vc_fifo u_fifo
		(
			.clk(clk),
			.reset(reset),
			.enqueue(enq[v]),
			.wdata(wr_flit),
			.dequeue(dequeue[v]),
			.rdata(front),
			.empty(fifo_empty[v]),
			.full(fifo_full[v])
		);

		// reservation, header never reserves
		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				state <= vc_idle;
				up_tag <= '0;
			end
			else if (enq[v])
			begin
				if (link_in.flit.kind == head_flit)
				begin
					state <= vc_busy;
					up_tag <= link_in.flit.vc;
				end
				else if (link_in.flit.kind == tail_flit)
					state <= vc_idle; // released as the tail goes in
			end
		end

		// a new head can sit behind the previous tail in the fifo,
		// so the route is captured as the head leaves, not as it arrives
		always_ff @(posedge clk)
		begin
			if (reset)
				route <= stop;
			else if (dequeue[v] && (front.kind == head_flit))
				route <= route_dir(node_id, flit_dest(front));
		end

		// head at the front routes from its own dest, followers use the latch
		assign heads[v] = '{
			pending: !fifo_empty[v],
			dir: is_head_like(front.kind) ? route_dir(node_id, flit_dest(front)) : route,
			flit: front
		};
	end
endgenerate

assign status.ready = ready;
assign status.full = fifo_full;

endmodule

// ==== output_link.sv ====
// output of a node, switch arbitration with wormhole lock, back-pressure, output register
`timescale 1ns/100ps

module output_link import spidergon_pkg::*;
#(
	parameter logic [node_w-1:0] node_id = '0,
	parameter link_dir_e out_dir = stop // link served, stop for the cpu
)
(
	input  logic                             clk,
	input  logic                             reset,
	input  vc_head_t [num_requesters-1:0]    heads, // all six channel fronts
	input  vc_status_t                       neighbour, // unused when out_dir is stop
	output logic [num_requesters-1:0]        grant, // dequeue strobe per channel
	output flit_link_t                       out
);

localparam logic eject = (out_dir == stop);

logic [num_requesters-1:0] eligible;
logic [num_requesters-1:0] req;
logic [num_requesters-1:0] lock_sel; // channel owning the output
logic locked; // between a head and its tail
logic link_free;
logic head_ok;
logic body_ok;
logic out_valid;
flit_t out_flit;
flit_t win_flit;

// a flit still on the wire is not yet in the neighbour status,
// so a link carries one flit at a time, the cpu side streams
assign link_free = eject || !out_valid;

// head needs any ready channel downstream
assign head_ok = link_free && (eject || (|neighbour.ready));
// followers stop if any reserved channel downstream is full
assign body_ok = link_free && (eject || !(|(~neighbour.ready & neighbour.full)));

always_comb
begin
	for (int i = 0; i < num_requesters; i++)
	begin
		if (is_head_like(heads[i].flit.kind))
			eligible[i] = heads[i].pending && (heads[i].dir == out_dir) && head_ok
				&& ((flit_dest(heads[i].flit) == node_id) == eject); // own dest ejects
		else
			eligible[i] = heads[i].pending && (heads[i].dir == out_dir) && body_ok;
	end
end

// while locked only the owner may speak
assign req = locked ? (eligible & lock_sel) : eligible;

rr_arbiter #(.n(num_requesters)) u_switch
(
	.clk(clk),
	.reset(reset),
	.req(req),
	.grant(grant)
);

always_comb
begin
	win_flit = '0;
	for (int i = 0; i < num_requesters; i++)
	begin
		if (grant[i])
			win_flit = heads[i].flit;
	end
end

// wormhole lock, header passes without locking
always_ff @(posedge clk)
begin
	if (reset)
	begin
		locked <= 1'b0;
		lock_sel <= '0;
	end
	else if (|grant)
	begin
		if (win_flit.kind == head_flit)
		begin
			locked <= 1'b1;
			lock_sel <= grant;
		end
		else if (win_flit.kind == tail_flit)
			locked <= 1'b0;
	end
end

always_ff @(posedge clk)
begin
	if (reset)
		out_valid <= 1'b0;
	else
		out_valid <= |grant; // flit shows the cycle after dequeue
end

always_ff @(posedge clk)
begin
	if (|grant)
		out_flit <= win_flit;
end

assign out = '{valid: out_valid, flit: out_flit};

endmodule

// ==== rr_arbiter.sv ====
// round-robin arbiter with a one-hot last-grant pointer
`timescale 1ns/100ps

module rr_arbiter
#(
	parameter int n = 2 // number of requesters
)
(
	input  logic         clk,
	input  logic         reset,
	input  logic [n-1:0] req,
	output logic [n-1:0] grant // one-hot, zero when nothing requests
);

logic [n-1:0] last_grant; // one-hot, requester served most recently
logic [n-1:0] upper_mask; // positions strictly above last_grant
logic [n-1:0] upper_req;

assign upper_mask = ~((last_grant - 1'b1) | last_grant);
assign upper_req = req & upper_mask;

// lowest set bit above the pointer, else wrap to the lowest overall
always_comb
begin
	if (|upper_req)
		grant = upper_req & (~upper_req + 1'b1);
	else
		grant = req & (~req + 1'b1);
end

// pointer only moves when somebody actually wins
always_ff @(posedge clk)
begin
	if (reset)
		last_grant <= {1'b1, {(n-1){1'b0}}}; // top bit so index 0 goes first
	else if (|grant)
		last_grant <= grant;
end

endmodule

// ==== spidergon_node.f ====
spidergon_pkg.sv
rr_arbiter.sv
vc_fifo.sv
input_port.sv
output_link.sv
spidergon_node.sv
spidergon_node_assertions.sv
tb_spidergon_node.sv

// ==== spidergon_node.sv ====
// spidergon node top, three input links feeding three link outputs and cpu ejection
`timescale 1ns/100ps

module spidergon_node import spidergon_pkg::*;
#(
	parameter logic [node_w-1:0] node_id = '0 // ring position
)
(
	input  logic       clk,
	input  logic       reset,
	input  flit_link_t link_in [num_links], // indexed by link_dir_e
	input  vc_status_t neighbour_status [num_links],
	output flit_link_t link_out [num_links],
	output vc_status_t node_status [num_links],
	output flit_link_t cpu_out
);

vc_head_t [num_requesters-1:0] heads; // entry is link * num_vcs + channel
logic [num_requesters-1:0] grants [num_links+1]; // last entry is the cpu output
logic [num_requesters-1:0] dequeue;

// a channel targets one direction only, so grants never overlap
always_comb
begin
	dequeue = '0;
	for (int o = 0; o <= num_links; o++)
		dequeue = dequeue | grants[o];
end

genvar l;
generate
	for (l = 0; l < num_links; l++)
	begin : g_link
		input_port #(.node_id(node_id)) u_in
		(
			.clk(clk),
			.reset(reset),
			.link_in(link_in[l]),
			.dequeue(dequeue[l*num_vcs +: num_vcs]),
			.status(node_status[l]),
			.heads(heads[l*num_vcs +: num_vcs])
		);

		output_link #(.node_id(node_id), .out_dir(link_dir_e'(l))) u_out
		(
			.clk(clk),
			.reset(reset),
			.heads(heads),
			.neighbour(neighbour_status[l]),
			.grant(grants[l]),
			.out(link_out[l])
		);
	end
endgenerate

// cpu side has no flow control back to the node
output_link #(.node_id(node_id), .out_dir(stop)) u_eject
(
	.clk(clk),
	.reset(reset),
	.heads(heads),
	.neighbour('0),
	.grant(grants[num_links]),
	.out(cpu_out)
);

endmodule

// ==== spidergon_node_assertions.sv ====
// concurrent checks on node outputs, status and wormhole framing, bound into the node
`timescale 1ns/100ps

module spidergon_node_assertions import spidergon_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input flit_link_t link_in [num_links],
	input vc_status_t neighbour_status [num_links],
	input flit_link_t link_out [num_links],
	input vc_status_t node_status [num_links],
	input flit_link_t cpu_out
);

flit_link_t outs [num_links+1]; // cpu output last
logic in_pkt [num_links+1]; // output is between a head and its tail

always_comb
begin
	for (int o = 0; o < num_links; o++)
		outs[o] = link_out[o];
	outs[num_links] = cpu_out;
end

always_ff @(posedge clk)
begin
	for (int o = 0; o <= num_links; o++)
	begin
		if (reset)
			in_pkt[o] <= 1'b0;
		else if (outs[o].valid && outs[o].flit.kind == head_flit)
			in_pkt[o] <= 1'b1;
		else if (outs[o].valid && outs[o].flit.kind == tail_flit)
			in_pkt[o] <= 1'b0;
	end
end

genvar o;
generate
	for (o = 0; o <= num_links; o++)
	begin : g_out
		// idle outputs right after reset
		a_reset_quiet: assert property (@(posedge clk) reset |=> !outs[o].valid)
			else $error("output %0d valid right after reset", o);

		// no new packet may cut into a locked packet
		a_wormhole: assert property (@(posedge clk) disable iff (reset)
			(outs[o].valid && in_pkt[o]) |->
			(outs[o].flit.kind == body_flit || outs[o].flit.kind == tail_flit))
			else $error("packet interleaved on output %0d", o);
	end

	for (o = 0; o < num_links; o++)
	begin : g_link
		a_reset_status: assert property (@(posedge clk) reset |=>
			(node_status[o].ready == '1 && node_status[o].full == '0))
			else $error("link %0d status not clean after reset", o);

		a_head_needs_ready: assert property (@(posedge clk) disable iff (reset)
			(link_out[o].valid && is_head_like(link_out[o].flit.kind)) |->
			$past(|neighbour_status[o].ready))
			else $error("head left on link %0d with no ready channel downstream", o);

		// reserved and full downstream channel blocks followers
		a_body_needs_room: assert property (@(posedge clk) disable iff (reset)
			(link_out[o].valid && !is_head_like(link_out[o].flit.kind)) |->
			$past(!(|(~neighbour_status[o].ready & neighbour_status[o].full))))
			else $error("body or tail left on link %0d into a full channel", o);

		a_head_reserves: assert property (@(posedge clk) disable iff (reset)
			(link_in[o].valid && link_in[o].flit.kind == head_flit) |=>
			!(&node_status[o].ready))
			else $error("head on input %0d reserved no channel", o);

		// senders keep one packet in flight per link so the tail leaves no channel reserved
		a_tail_releases: assert property (@(posedge clk) disable iff (reset)
			(link_in[o].valid && link_in[o].flit.kind == tail_flit) |=>
			(&(node_status[o].ready | node_status[o].full)))
			else $error("tail on input %0d left its channel reserved", o);
	end
endgenerate

endmodule

bind spidergon_node spidergon_node_assertions u_chk
(
	.clk(clk),
	.reset(reset),
	.link_in(link_in),
	.neighbour_status(neighbour_status),
	.link_out(link_out),
	.node_status(node_status),
	.cpu_out(cpu_out)
);

// ==== spidergon_pkg.sv ====
// spidergon node shared types, sizes and the ring routing function
package spidergon_pkg;

localparam int num_nodes = 8; // nodes on the ring
localparam int node_w = 3; // bits in a node number
localparam int num_vcs = 2; // virtual channels per input link
localparam int vc_w = 1; // bits in a channel tag
localparam int num_links = 3; // anticlockwise, clockwise, across
localparam int flit_data_w = 16;
localparam int vc_depth = 2; // flits per channel fifo
localparam int num_requesters = 6; // channels competing for one output

// header is a whole packet in one flit
typedef enum logic [1:0] {
	tail_flit = 2'b00,
	head_flit = 2'b01,
	body_flit = 2'b10,
	header    = 2'b11
} flit_kind_e;

// first three values double as link index, stop means eject to cpu
typedef enum logic [1:0] {
	anticlockwise = 2'd0,
	clockwise     = 2'd1,
	across        = 2'd2,
	stop          = 2'd3
} link_dir_e;

// head data is {dest, source, 10-bit payload}
typedef struct packed {
	flit_kind_e kind;
	logic [vc_w-1:0] vc; // channel tag at the sending node
	logic [flit_data_w-1:0] data;
} flit_t;

typedef struct packed {
	logic valid;
	flit_t flit;
} flit_link_t;

typedef struct packed {
	logic [num_vcs-1:0] ready; // unreserved and not full
	logic [num_vcs-1:0] full;
} vc_status_t;

// front of one channel as seen by every output
typedef struct packed {
	logic pending; // fifo holds at least one flit
	link_dir_e dir;
	flit_t flit;
} vc_head_t;

function automatic logic is_head_like(input flit_kind_e kind);
	return (kind == head_flit) || (kind == header);
endfunction

function automatic logic [node_w-1:0] flit_dest(input flit_t f);
	return f.data[flit_data_w-1 -: node_w];
endfunction

// shortest way round the ring, across for the far half
function automatic link_dir_e route_dir(input logic [node_w-1:0] current,
		input logic [node_w-1:0] dest);
	int offset;
	offset = (int'(dest) + num_nodes - int'(current)) % num_nodes;
	if (offset == 0)
		return stop;
	else if (offset <= 2)
		return clockwise;
	else if (offset >= num_nodes - 2)
		return anticlockwise;
	return across;
endfunction

endpackage

// ==== tb_spidergon_node.sv ====
// testbench for one spidergon node, stimulus on three links, neighbour model and scoreboard
`timescale 1ns/100ps

module tb_spidergon_node import spidergon_pkg::*;
();

logic clk = 1'b0;
logic reset;
flit_link_t link_in [num_links];
vc_status_t neighbour_status [num_links];
flit_link_t link_out [num_links];
vc_status_t node_status [num_links];
flit_link_t cpu_out;

flit_t exp_q [4][$]; // expected flits per output, whole packets kept together
int cur_idx [4]; // position of the open packet in exp_q
logic active [4];
int unsigned rng_state = 32'h71ad;
int pkt_count = 0;
int cycles = 0;

spidergon_node #(.node_id(3'd0)) dut0
(
	.clk(clk),
	.reset(reset),
	.link_in(link_in),
	.neighbour_status(neighbour_status),
	.link_out(link_out),
	.node_status(node_status),
	.cpu_out(cpu_out)
);

always #2 clk = ~clk;

function automatic int unsigned lcg_next();
	rng_state = rng_state * 32'd1103515245 + 32'd12345;
	return rng_state;
endfunction

// ring offset from node 0, 3 means the cpu
function automatic int expected_out(int dest);
	if (dest == 0)
		return 3;
	else if (dest <= 2)
		return 1;
	else if (dest >= 6)
		return 0;
	return 2;
endfunction

task automatic report_error(string msg);
	$display("ERR %0t %s", $time, msg);
	$display("Testbench failed");
	$fatal(1);
endtask

task automatic check_flit(int o, flit_t f);
	int idx;
	idx = -1;
	if (f.kind == head_flit || f.kind == header)
	begin
		for (int i = 0; i < exp_q[o].size(); i++)
			if (idx < 0 && exp_q[o][i].kind == f.kind && exp_q[o][i].data == f.data)
				idx = i;
		if (idx < 0 || active[o])
			report_error($sformatf("unexpected head %h on output %0d", f.data, o));
		else
		begin
			exp_q[o].delete(idx);
			cur_idx[o] = idx;
			active[o] = (f.kind == head_flit);
		end
	end
	else if (!active[o])
		report_error($sformatf("follower %h on output %0d with no open packet", f.data, o));
	else if (exp_q[o][cur_idx[o]].kind != f.kind || exp_q[o][cur_idx[o]].data != f.data)
		report_error($sformatf("output %0d got %h, expected %h", o, f,
			exp_q[o][cur_idx[o]]));
	else
	begin
		exp_q[o].delete(cur_idx[o]);
		active[o] = (f.kind != tail_flit);
	end
endtask

// outputs are registered on the rising edge, read them half a cycle later
always @(negedge clk)
begin
	if (!reset)
	begin
		for (int o = 0; o < num_links; o++)
			if (link_out[o].valid)
				check_flit(o, link_out[o].flit);
		if (cpu_out.valid)
			check_flit(3, cpu_out.flit);
	end
end

always @(posedge clk)
begin
	cycles <= cycles + 1;
	if (cycles >= 3000)
	begin
		$display("run hung, expected flits never arrived before the cycle limit");
		$display("Testbench failed");
		$fatal(1);
	end
end

// one packet on one link, len 1 is a single header flit
task automatic send_packet(int l, int dest, int len);
	flit_t pkt [$];
	flit_t f;
	for (int k = 0; k < len; k++)
	begin
		if (k == 0)
			f.kind = (len == 1) ? header : head_flit;
		else
			f.kind = (k == len - 1) ? tail_flit : body_flit;
		f.vc = 1'b0; // one packet in flight per link
		if (k == 0)
			f.data = {3'(dest), 3'(l), 10'(pkt_count)};
		else
			f.data = 16'(lcg_next() >> 8);
		pkt.push_back(f);
	end
	pkt_count++;
	foreach (pkt[k])
		exp_q[expected_out(dest)].push_back(pkt[k]);
	foreach (pkt[k])
	begin
		// obey the node's status like a real upstream node
		if (k == 0)
			while (!(|node_status[l].ready))
				@(negedge clk);
		else
			while (|node_status[l].full)
				@(negedge clk);
		link_in[l] = '{valid: 1'b1, flit: pkt[k]};
		@(negedge clk);
		link_in[l].valid = 1'b0;
	end
endtask

task automatic wait_drain();
	while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() > 0)
		@(negedge clk);
	repeat (4) @(negedge clk);
endtask

task automatic send_random(int l, int count);
	for (int p = 0; p < count; p++)
		send_packet(l, 3 + int'(lcg_next() % 3), 1 + int'(lcg_next() % 4));
endtask

initial
begin
	reset = 1'b1;
	for (int l = 0; l < num_links; l++)
	begin
		link_in[l] = '0;
		neighbour_status[l] = '{ready: 2'b11, full: 2'b00};
	end
	for (int o = 0; o < 4; o++)
	begin
		active[o] = 1'b0;
		cur_idx[o] = 0;
	end
	repeat (4) @(negedge clk);
	reset = 1'b0;
	@(negedge clk);

	// routing, every destination from every link
	for (int l = 0; l < num_links; l++)
		for (int d = 0; d < num_nodes; d++)
			send_packet(l, d, 1);
	wait_drain();

	// wormhole packets on all links at once, one of them ejects
	fork
		send_packet(0, 1, 4);
		send_packet(1, 4, 5);
		send_packet(2, 0, 3);
	join
	wait_drain();

	// neighbour on clockwise has no free channel, head must wait
	neighbour_status[1] = '{ready: 2'b00, full: 2'b00};
	fork
		send_packet(0, 2, 4);
	join_none
	repeat (20) @(negedge clk);
	if (node_status[0].full == 2'b00)
		report_error("stalled channel did not raise its full bit");
	// one channel ready, the other reserved and full, followers wait
	neighbour_status[1] = '{ready: 2'b10, full: 2'b01};
	repeat (20) @(negedge clk);
	neighbour_status[1] = '{ready: 2'b11, full: 2'b00};
	wait fork;
	wait_drain();

	// contention, all links into the across half
	fork
		send_random(0, 6);
		send_random(1, 6);
		send_random(2, 6);
	join
	wait_drain();

	if (active[0] || active[1] || active[2] || active[3])
	begin
		$display("a packet was left open on an output at the end of the run");
		$display("Testbench failed");
		$fatal(1);
	end
	else
	begin
		$display("Testbench passed");
		$finish;
	end
end

endmodule

// ==== vc_fifo.sv ====
// virtual channel buffer, small circular fifo with fall-through front
`timescale 1ns/100ps

module vc_fifo import spidergon_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  enqueue,
	input  flit_t wdata,
	input  logic  dequeue,
	output flit_t rdata, // front entry, valid while not empty
	output logic  empty,
	output logic  full
);

flit_t mem [vc_depth];
logic [$clog2(vc_depth)-1:0] wr_ptr;
logic [$clog2(vc_depth)-1:0] rd_ptr;
logic [$clog2(vc_depth+1)-1:0] count; // flits held
logic do_wr;
logic do_rd;

assign do_wr = enqueue && !full; // writes into a full buffer are lost
assign do_rd = dequeue && !empty;
assign empty = (count == 0);
assign full = (count == vc_depth);
assign rdata = mem[rd_ptr];

always_ff @(posedge clk)
begin
	if (do_wr)
		mem[wr_ptr] <= wdata;
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end
	else
	begin
		if (do_wr)
			wr_ptr <= (int'(wr_ptr) == vc_depth - 1) ? '0 : wr_ptr + 1'b1;
		if (do_rd)
			rd_ptr <= (int'(rd_ptr) == vc_depth - 1) ? '0 : rd_ptr + 1'b1;
		case ({do_wr, do_rd})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count; // idle or pass-through
		endcase
	end
end

endmodule
